// ==== build.f ====
design/glbPkg.sv
design/portWindow.sv
design/writeFrontEnd.sv
design/readFrontEnd.sv
design/bankSlice.sv
design/glbTop.sv
testbench/glbTb.sv

// ==== design/bankSlice.sv ====
`timescale 1ns/100ps

module bankSlice
    import glbPkg::*;
#(
    parameter int BANK_WORDS = 16,
    parameter int NUM_WRPORT = 2,
    parameter int NUM_RDPORT = 2
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_WRPORT+NUM_RDPORT-1:0] bankMasks_i,
    input  wrReqT [NUM_WRPORT-1:0]           wrReq_i,
    input  rdReqT [NUM_RDPORT-1:0]           rdReq_i,
    input  logic [NUM_RDPORT-1:0]            dataReady_i,
    output logic                             wrReady_o,
    output logic                             rdReady_o,
    output logic                             rdValid_o,
    output dataT                             rdData_o,
    output progressT                         wrProgress_o,
    output progressT                         rdProgress_o
);

    localparam int WORD_W = $clog2(BANK_WORDS);
    localparam int WP_W   = (NUM_WRPORT > 1) ? $clog2(NUM_WRPORT) : 1;
    localparam int RP_W   = (NUM_RDPORT > 1) ? $clog2(NUM_RDPORT) : 1;

    dataT mem [BANK_WORDS];

    logic [WP_W-1:0] wrOwner;
    logic [WP_W-1:0] wrOwnerQ;
    logic wrOwned;
    logic wrOwnedQ;
    logic [RP_W-1:0] rdOwner;
    logic [RP_W-1:0] rdOwnerQ;
    logic rdOwned;
    logic rdOwnedQ;
    logic wrChange;
    logic rdChange;

    wrReqT wrSel;
    rdReqT rdSel;
    logic wrFire;
    logic rdFire;
    logic consumed;
    rdSlotE slotQ;
    dataT holdQ;

    // ============================================================
    // Owner selection, lowest port index wins
    // ============================================================
    always_comb begin
        wrOwner = '0;
        wrOwned = 1'b0;
        for (int p = NUM_WRPORT - 1; p >= 0; p--) begin
            if (bankMasks_i[p]) begin
                wrOwner = WP_W'(p);
                wrOwned = 1'b1;
            end
        end
        rdOwner = '0;
        rdOwned = 1'b0;
        for (int p = NUM_RDPORT - 1; p >= 0; p--) begin
            if (bankMasks_i[NUM_WRPORT+p]) begin
                rdOwner = RP_W'(p);
                rdOwned = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrOwnerQ <= '0;
            wrOwnedQ <= 1'b0;
            rdOwnerQ <= '0;
            rdOwnedQ <= 1'b0;
        end else begin
            wrOwnerQ <= wrOwner;
            wrOwnedQ <= wrOwned;
            rdOwnerQ <= rdOwner;
            rdOwnedQ <= rdOwned;
        end
    end

    assign wrChange = (wrOwned != wrOwnedQ) || (wrOwner != wrOwnerQ);
    assign rdChange = (rdOwned != rdOwnedQ) || (rdOwner != rdOwnerQ);

    // ============================================================
    // Handshakes on the single SRAM port
    // ============================================================
    assign wrSel    = wrReq_i[wrOwner];
    assign rdSel    = rdReq_i[rdOwner];
    assign consumed = (slotQ == SLOT_FULL) && dataReady_i[rdOwnerQ];

    assign rdReady_o = rdOwnedQ && !rdChange && ((slotQ == SLOT_EMPTY) || consumed);
    assign rdFire    = rdSel.valid && rdReady_o;
    // Reads take the port first
    assign wrReady_o = wrOwnedQ && !wrChange && !rdFire;
    assign wrFire    = wrSel.valid && wrReady_o;

    always_ff @(posedge clk) begin
        if (wrFire) begin
            mem[wrSel.addr[WORD_W-1:0]] <= wrSel.data;
        end
        if (rdFire) begin
            holdQ <= mem[rdSel.addr[WORD_W-1:0]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slotQ <= SLOT_EMPTY;
        end else if (rdFire) begin
            slotQ <= SLOT_FULL;
        end else if (consumed) begin
            slotQ <= SLOT_EMPTY;
        end
    end

    assign rdValid_o = (slotQ == SLOT_FULL);
    assign rdData_o  = holdQ;

    // ============================================================
    // Progress, cleared after an owner change
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrProgress_o <= '0;
            rdProgress_o <= '0;
        end else begin
            if (wrChange) begin
                wrProgress_o <= '0;
            end else if (wrFire) begin
                wrProgress_o <= '{addr: wrSel.addr, touched: 1'b1};
            end
            if (rdChange) begin
                rdProgress_o <= '0;
            end else if (rdFire) begin
                rdProgress_o <= '{addr: rdSel.addr, touched: 1'b1};
            end
        end
    end

    // A held word is never overwritten before the reader takes it
    slotHeld: assert property (@(posedge clk) disable iff (!rst_n)
        (slotQ == SLOT_FULL && !consumed) |=> (slotQ == SLOT_FULL && $stable(holdQ)));

endmodule

// ==== design/glbPkg.sv ====
package glbPkg;

    // ============================================================
    // Word and address widths
    // ============================================================
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 8;

    typedef logic [DATA_WIDTH-1:0] dataT;
    typedef logic [ADDR_WIDTH-1:0] addrT;

    // ============================================================
    // Front end to bank requests
    // ============================================================

    // The bank takes its word index from the low bits of addr
    typedef struct packed {
        logic valid;
        addrT addr;
        dataT data;
    } wrReqT;

    typedef struct packed {
        logic valid;
        addrT addr;
    } rdReqT;

    // Last handshaken port address of a bank, one per direction
    typedef struct packed {
        addrT addr;
        logic touched;
    } progressT;

    // Read data hold register of a bank
    typedef enum logic {
        SLOT_EMPTY = 1'b0,
        SLOT_FULL  = 1'b1
    } rdSlotE;

endpackage

// ==== design/glbTop.sv ====
`timescale 1ns/100ps

module glbTop
    import glbPkg::*;
#(
    parameter int NUM_BANK   = 4,
    parameter int BANK_WORDS = 16,
    parameter int NUM_WRPORT = 2,
    parameter int NUM_RDPORT = 2
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic [NUM_WRPORT+NUM_RDPORT-1:0][NUM_BANK-1:0] cfgBankMask_i,
    input  logic [NUM_WRPORT+NUM_RDPORT-1:0]               cfgBypass_i,
    input  addrT [NUM_WRPORT-1:0]                          wrAddr_i,
    input  dataT [NUM_WRPORT-1:0]                          wrData_i,
    input  logic [NUM_WRPORT-1:0]                          wrValid_i,
    output logic [NUM_WRPORT-1:0]                          wrReady_o,
    output logic [NUM_WRPORT-1:0]                          wrFull_o,
    input  addrT [NUM_RDPORT-1:0]                          rdAddr_i,
    input  logic [NUM_RDPORT-1:0]                          rdAddrValid_i,
    output logic [NUM_RDPORT-1:0]                          rdAddrReady_o,
    output logic [NUM_RDPORT-1:0]                          rdEmpty_o,
    output dataT [NUM_RDPORT-1:0]                          rdData_o,
    output logic [NUM_RDPORT-1:0]                          rdDataValid_o,
    input  logic [NUM_RDPORT-1:0]                          rdDataReady_i
);

    localparam int NUM_PORT = NUM_WRPORT + NUM_RDPORT;
    localparam int BIDX_W   = $clog2(NUM_BANK);
    localparam int CNT_W    = $clog2(NUM_BANK + 1);

    // Bank side results, shared by all front ends
    logic [NUM_BANK-1:0] bankWrReady;
    logic [NUM_BANK-1:0] bankRdReady;
    logic [NUM_BANK-1:0] bankRdValid;
    dataT [NUM_BANK-1:0] bankRdData;
    progressT [NUM_BANK-1:0] bankWrProgress;
    progressT [NUM_BANK-1:0] bankRdProgress;

    // Per port, per bank request lines
    wrReqT [NUM_BANK-1:0] portWrReq [NUM_WRPORT];
    rdReqT [NUM_BANK-1:0] portRdReq [NUM_RDPORT];
    logic [NUM_BANK-1:0] portDataReady [NUM_RDPORT];

    // ============================================================
    // Write ports
    // ============================================================
    for (genvar p = 0; p < NUM_WRPORT; p++) begin : genWrPort
        logic [BIDX_W-1:0] firstBank;
        logic [CNT_W-1:0] bankCount;
        logic [ADDR_WIDTH:0] windowSize;
        logic [BIDX_W-1:0] targetBank;

        portWindow #(
            .NUM_BANK   (NUM_BANK),
            .BANK_WORDS (BANK_WORDS)
        ) uWindow (
            .bankMask_i   (cfgBankMask_i[p]),
            .addr_i       (wrAddr_i[p]),
            .firstBank_o  (firstBank),
            .bankCount_o  (bankCount),
            .windowSize_o (windowSize),
            .targetBank_o (targetBank)
        );

        writeFrontEnd #(
            .NUM_BANK (NUM_BANK)
        ) uWrFe (
            .clk              (clk),
            .rst_n            (rst_n),
            .firstBank_i      (firstBank),
            .bankCount_i      (bankCount),
            .windowSize_i     (windowSize),
            .targetBank_i     (targetBank),
            .addr_i           (wrAddr_i[p]),
            .data_i           (wrData_i[p]),
            .valid_i          (wrValid_i[p]),
            .bypass_i         (cfgBypass_i[p]),
            .bankRdProgress_i (bankRdProgress),
            .bankWrReady_i    (bankWrReady),
            .ready_o          (wrReady_o[p]),
            .full_o           (wrFull_o[p]),
            .wrReq_o          (portWrReq[p])
        );
    end

    // ============================================================
    // Read ports
    // ============================================================
    for (genvar p = 0; p < NUM_RDPORT; p++) begin : genRdPort
        logic [BIDX_W-1:0] firstBank;
        logic [CNT_W-1:0] bankCount;
        logic [ADDR_WIDTH:0] windowSize;
        logic [BIDX_W-1:0] targetBank;

        portWindow #(
            .NUM_BANK   (NUM_BANK),
            .BANK_WORDS (BANK_WORDS)
        ) uWindow (
            .bankMask_i   (cfgBankMask_i[NUM_WRPORT+p]),
            .addr_i       (rdAddr_i[p]),
            .firstBank_o  (firstBank),
            .bankCount_o  (bankCount),
            .windowSize_o (windowSize),
            .targetBank_o (targetBank)
        );

        readFrontEnd #(
            .NUM_BANK (NUM_BANK)
        ) uRdFe (
            .clk              (clk),
            .rst_n            (rst_n),
            .firstBank_i      (firstBank),
            .bankCount_i      (bankCount),
            .windowSize_i     (windowSize),
            .targetBank_i     (targetBank),
            .addr_i           (rdAddr_i[p]),
            .addrValid_i      (rdAddrValid_i[p]),
            .bypass_i         (cfgBypass_i[NUM_WRPORT+p]),
            .bankWrProgress_i (bankWrProgress),
            .bankAddrReady_i  (bankRdReady),
            .bankDataValid_i  (bankRdValid),
            .bankData_i       (bankRdData),
            .dataReady_i      (rdDataReady_i[p]),
            .addrReady_o      (rdAddrReady_o[p]),
            .empty_o          (rdEmpty_o[p]),
            .rdReq_o          (portRdReq[p]),
            .data_o           (rdData_o[p]),
            .dataValid_o      (rdDataValid_o[p]),
            .bankDataReady_o  (portDataReady[p])
        );
    end

    // ============================================================
    // Banks
    // ============================================================
    for (genvar b = 0; b < NUM_BANK; b++) begin : genBank
        logic [NUM_PORT-1:0] masks;
        wrReqT [NUM_WRPORT-1:0] wrReq;
        rdReqT [NUM_RDPORT-1:0] rdReq;
        logic [NUM_RDPORT-1:0] dataReady;

        // Gather this bank's column from every port
        for (genvar p = 0; p < NUM_PORT; p++) begin : genMask
            assign masks[p] = cfgBankMask_i[p][b];
        end
        for (genvar p = 0; p < NUM_WRPORT; p++) begin : genWr
            assign wrReq[p] = portWrReq[p][b];
        end
        for (genvar p = 0; p < NUM_RDPORT; p++) begin : genRd
            assign rdReq[p]     = portRdReq[p][b];
            assign dataReady[p] = portDataReady[p][b];
        end

        bankSlice #(
            .BANK_WORDS (BANK_WORDS),
            .NUM_WRPORT (NUM_WRPORT),
            .NUM_RDPORT (NUM_RDPORT)
        ) uBank (
            .clk          (clk),
            .rst_n        (rst_n),
            .bankMasks_i  (masks),
            .wrReq_i      (wrReq),
            .rdReq_i      (rdReq),
            .dataReady_i  (dataReady),
            .wrReady_o    (bankWrReady[b]),
            .rdReady_o    (bankRdReady[b]),
            .rdValid_o    (bankRdValid[b]),
            .rdData_o     (bankRdData[b]),
            .wrProgress_o (bankWrProgress[b]),
            .rdProgress_o (bankRdProgress[b])
        );
    end

endmodule

// ==== design/portWindow.sv ====
`timescale 1ns/100ps

module portWindow
    import glbPkg::*;
#(
    parameter int NUM_BANK   = 4,
    parameter int BANK_WORDS = 16
) (
    input  logic [NUM_BANK-1:0]            bankMask_i,
    input  addrT                           addr_i,
    output logic [$clog2(NUM_BANK)-1:0]    firstBank_o,
    output logic [$clog2(NUM_BANK+1)-1:0]  bankCount_o,
    output logic [ADDR_WIDTH:0]            windowSize_o,
    output logic [$clog2(NUM_BANK)-1:0]    targetBank_o
);

    localparam int BIDX_W = $clog2(NUM_BANK);
    localparam int CNT_W  = $clog2(NUM_BANK + 1);
    localparam int WORD_W = $clog2(BANK_WORDS);
    localparam int WIN_W  = ADDR_WIDTH + 1;

    logic [CNT_W-1:0] effCount;
    addrT bankOffset;

    // Lowest set bit and population count of the mask
    always_comb begin
        firstBank_o = '0;
        bankCount_o = '0;
        for (int i = NUM_BANK - 1; i >= 0; i--) begin
            if (bankMask_i[i]) begin
                firstBank_o = BIDX_W'(i);
            end
        end
        for (int i = 0; i < NUM_BANK; i++) begin
            bankCount_o = bankCount_o + CNT_W'(bankMask_i[i]);
        end
    end

    // Empty mask still gets a one bank window
    assign effCount     = (bankCount_o == '0) ? CNT_W'(1) : bankCount_o;
    assign windowSize_o = WIN_W'(BANK_WORDS) * WIN_W'(effCount);

    // Upper address bits select the bank inside the window
    assign bankOffset   = (addr_i >> WORD_W) % ADDR_WIDTH'(effCount);
    assign targetBank_o = firstBank_o + bankOffset[BIDX_W-1:0];

endmodule

// ==== design/readFrontEnd.sv ====
`timescale 1ns/100ps

module readFrontEnd
    import glbPkg::*;
#(
    parameter int NUM_BANK = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [$clog2(NUM_BANK)-1:0]       firstBank_i,
    input  logic [$clog2(NUM_BANK+1)-1:0]     bankCount_i,
    input  logic [ADDR_WIDTH:0]               windowSize_i,
    input  logic [$clog2(NUM_BANK)-1:0]       targetBank_i,
    input  addrT                              addr_i,
    input  logic                              addrValid_i,
    input  logic                              bypass_i,
    input  progressT [NUM_BANK-1:0]           bankWrProgress_i,
    input  logic [NUM_BANK-1:0]               bankAddrReady_i,
    input  logic [NUM_BANK-1:0]               bankDataValid_i,
    input  dataT [NUM_BANK-1:0]               bankData_i,
    input  logic                              dataReady_i,
    output logic                              addrReady_o,
    output logic                              empty_o,
    output rdReqT [NUM_BANK-1:0]              rdReq_o,
    output dataT                              data_o,
    output logic                              dataValid_o,
    output logic [NUM_BANK-1:0]               bankDataReady_o
);

    localparam int BIDX_W = $clog2(NUM_BANK);

    addrT maxWrAddr;
    logic anyWritten;
    logic hasBanks;
    logic inWindow;
    logic canIssue;
    logic addrFire;
    logic dataDone;
    logic [BIDX_W-1:0] scanBank;
    logic [BIDX_W-1:0] retBank;
    logic retVld;

    // ============================================================
    // Empty rule
    // ============================================================
    always_comb begin
        maxWrAddr  = '0;
        anyWritten = 1'b0;
        scanBank   = firstBank_i;
        for (int i = 0; i < NUM_BANK; i++) begin
            scanBank = firstBank_i + BIDX_W'(i);
            if (i < int'(bankCount_i) && bankWrProgress_i[scanBank].touched) begin
                anyWritten = 1'b1;
                if (bankWrProgress_i[scanBank].addr > maxWrAddr) begin
                    maxWrAddr = bankWrProgress_i[scanBank].addr;
                end
            end
        end
    end

    // Address must sit inside the window's written span
    assign inWindow = {1'b0, addr_i} < windowSize_i;
    assign empty_o  = !bypass_i && (!anyWritten || addr_i > maxWrAddr || !inWindow);
    assign hasBanks = (bankCount_i != '0);

    // New address only once the previous word leaves this port
    assign dataDone    = dataValid_o && dataReady_i;
    assign canIssue    = !retVld || dataDone;
    assign addrReady_o = hasBanks && !empty_o && canIssue && bankAddrReady_i[targetBank_i];
    assign addrFire    = addrValid_i && addrReady_o;

    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            rdReq_o[b].valid = addrValid_i && hasBanks && !empty_o && canIssue &&
                               (targetBank_i == BIDX_W'(b));
            rdReq_o[b].addr  = addr_i;
            bankDataReady_o[b] = dataReady_i && retVld && (retBank == BIDX_W'(b));
        end
    end

    // ============================================================
    // Data return
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retVld  <= 1'b0;
            retBank <= '0;
        end else if (addrFire) begin
            retVld  <= 1'b1;
            retBank <= targetBank_i;
        end else if (dataDone) begin
            retVld  <= 1'b0;
        end
    end

    assign dataValid_o = retVld && bankDataValid_i[retBank];
    assign data_o      = bankData_i[retBank];

    // Returned word holds through back-pressure
    dataHeld: assert property (@(posedge clk) disable iff (!rst_n)
        (dataValid_o && !dataReady_i) |=> (dataValid_o && $stable(data_o)));

endmodule

// ==== design/writeFrontEnd.sv ====
`timescale 1ns/100ps

module writeFrontEnd
    import glbPkg::*;
#(
    parameter int NUM_BANK = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [$clog2(NUM_BANK)-1:0]       firstBank_i,
    input  logic [$clog2(NUM_BANK+1)-1:0]     bankCount_i,
    input  logic [ADDR_WIDTH:0]               windowSize_i,
    input  logic [$clog2(NUM_BANK)-1:0]       targetBank_i,
    input  addrT                              addr_i,
    input  dataT                              data_i,
    input  logic                              valid_i,
    input  logic                              bypass_i,
    input  progressT [NUM_BANK-1:0]           bankRdProgress_i,
    input  logic [NUM_BANK-1:0]               bankWrReady_i,
    output logic                              ready_o,
    output logic                              full_o,
    output wrReqT [NUM_BANK-1:0]              wrReq_o
);

    localparam int BIDX_W = $clog2(NUM_BANK);
    localparam int WIN_W  = ADDR_WIDTH + 1;

    addrT maxRdAddr;
    addrT wrDist;
    logic anyRead;
    logic hasBanks;
    logic [BIDX_W-1:0] scanBank;
    logic [WIN_W-1:0] fullLevel;
    logic [NUM_BANK-1:0] reqValid;

    // Highest read address over the banks of this window
    always_comb begin
        maxRdAddr = '0;
        anyRead   = 1'b0;
        scanBank  = firstBank_i;
        for (int i = 0; i < NUM_BANK; i++) begin
            scanBank = firstBank_i + BIDX_W'(i);
            if (i < int'(bankCount_i) && bankRdProgress_i[scanBank].touched) begin
                anyRead = 1'b1;
                if (bankRdProgress_i[scanBank].addr > maxRdAddr) begin
                    maxRdAddr = bankRdProgress_i[scanBank].addr;
                end
            end
        end
    end

    // One extra word of room once the reader has consumed something
    assign wrDist    = addr_i - maxRdAddr;
    assign fullLevel = anyRead ? windowSize_i + WIN_W'(1) : windowSize_i;
    assign full_o    = !bypass_i && ({1'b0, wrDist} >= fullLevel);
    assign hasBanks  = (bankCount_i != '0);
    assign ready_o   = hasBanks && !full_o && bankWrReady_i[targetBank_i];

    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            reqValid[b] = valid_i && hasBanks && !full_o && (targetBank_i == BIDX_W'(b));
            wrReq_o[b]  = '{valid: reqValid[b], addr: addr_i, data: data_i};
        end
    end

    // At most one bank sees this port's write in any cycle
    wrReqOneHot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(reqValid));

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module glbTb -o glbSim || exit 1
out="$(./obj_dir/glbSim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Test OK$" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== testbench/glbTb.sv ====
`timescale 1ns/100ps

module glbTb
    import glbPkg::*;
();

    localparam int NUM_BANK   = 4;
    localparam int BANK_WORDS = 16;
    localparam int NUM_WRPORT = 2;
    localparam int NUM_RDPORT = 2;
    localparam int NUM_PORT   = NUM_WRPORT + NUM_RDPORT;
    localparam int WP_W       = $clog2(NUM_WRPORT);
    localparam int RP_W       = $clog2(NUM_RDPORT);
    localparam int GP_W       = $clog2(NUM_PORT);
    localparam string TEST_FILE = "testbench/glbTests.txt";

    logic clk;
    logic rst_n;
    logic [NUM_PORT-1:0][NUM_BANK-1:0] cfgBankMask;
    logic [NUM_PORT-1:0] cfgBypass;
    addrT [NUM_WRPORT-1:0] wrAddr;
    dataT [NUM_WRPORT-1:0] wrData;
    logic [NUM_WRPORT-1:0] wrValid;
    logic [NUM_WRPORT-1:0] wrReady;
    logic [NUM_WRPORT-1:0] wrFull;
    addrT [NUM_RDPORT-1:0] rdAddr;
    logic [NUM_RDPORT-1:0] rdAddrValid;
    logic [NUM_RDPORT-1:0] rdAddrReady;
    logic [NUM_RDPORT-1:0] rdEmpty;
    dataT [NUM_RDPORT-1:0] rdData;
    logic [NUM_RDPORT-1:0] rdDataValid;
    logic [NUM_RDPORT-1:0] rdDataReady;

    integer seed;
    int cycleCount;
    int cycleLimit;
    // Cycles of read back-pressure for the next accepted read
    int stallLeft;

    glbTop #(
        .NUM_BANK   (NUM_BANK),
        .BANK_WORDS (BANK_WORDS),
        .NUM_WRPORT (NUM_WRPORT),
        .NUM_RDPORT (NUM_RDPORT)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfgBankMask_i (cfgBankMask),
        .cfgBypass_i   (cfgBypass),
        .wrAddr_i      (wrAddr),
        .wrData_i      (wrData),
        .wrValid_i     (wrValid),
        .wrReady_o     (wrReady),
        .wrFull_o      (wrFull),
        .rdAddr_i      (rdAddr),
        .rdAddrValid_i (rdAddrValid),
        .rdAddrReady_o (rdAddrReady),
        .rdEmpty_o     (rdEmpty),
        .rdData_o      (rdData),
        .rdDataValid_o (rdDataValid),
        .rdDataReady_i (rdDataReady)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ============================================================
    // Failure reporting and compare tasks
    // ============================================================
    task automatic failRun();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkData(input string name, input dataT got, input dataT exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            failRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            failRun();
        end
    endtask

    task automatic checkHandshake(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            failRun();
        end
    endtask

    task automatic verifyFieldCount(input int got, input int want);
        if (got != want) begin
            $display("Malformed line in test file, found %0d of %0d fields", got, want);
            failRun();
        end
    endtask

    // Run limit scales with the test file length
    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Run hung, no finish within %0d cycles", cycleLimit);
            failRun();
        end
    end

    // A port without banks must never accept anything
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_WRPORT; p++) begin
                if (cfgBankMask[p] == '0) begin
                    checkHandshake($sformatf("wrReady_o[%0d]", p), wrReady[p], 1'b0);
                end
            end
            for (int p = 0; p < NUM_RDPORT; p++) begin
                if (cfgBankMask[NUM_WRPORT+p] == '0) begin
                    checkHandshake($sformatf("rdAddrReady_o[%0d]", p), rdAddrReady[p], 1'b0);
                end
            end
        end
    end

    // ============================================================
    // Command tasks
    // ============================================================
    task automatic countFileLines(output int lines);
        int fd;
        int code;
        logic [8*128-1:0] lineBuf;
        lines = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open test file %s", TEST_FILE);
            failRun();
        end
        while (!$feof(fd)) begin
            code = $fgets(lineBuf, fd);
            if (code > 0) begin
                lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic idleGap();
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk);
    endtask

    task automatic applyConfig(input logic [GP_W-1:0] port, input logic [NUM_BANK-1:0] mask,
                               input logic bypass);
        @(posedge clk);
        #2;
        cfgBankMask[port] = mask;
        cfgBypass[port]   = bypass;
    endtask

    task automatic writeWord(input logic [WP_W-1:0] wp, input addrT addr, input dataT data,
                             input logic expFull);
        @(posedge clk);
        #2;
        wrAddr[wp]  = addr;
        wrData[wp]  = data;
        wrValid[wp] = !expFull;
        @(negedge clk);
        checkFlag($sformatf("wrFull_o[%0d]", wp), wrFull[wp], expFull);
        if (expFull) begin
            checkHandshake($sformatf("wrReady_o[%0d]", wp), wrReady[wp], 1'b0);
        end else begin
            while (!wrReady[wp]) begin
                @(negedge clk);
            end
            @(posedge clk);
            #2;
            wrValid[wp] = 1'b0;
        end
    endtask

    task automatic readWord(input logic [RP_W-1:0] rp, input addrT addr, input logic expEmpty,
                            input dataT expData);
        @(posedge clk);
        #2;
        rdAddr[rp]      = addr;
        rdAddrValid[rp] = !expEmpty;
        @(negedge clk);
        checkFlag($sformatf("rdEmpty_o[%0d]", rp), rdEmpty[rp], expEmpty);
        if (expEmpty) begin
            checkHandshake($sformatf("rdAddrReady_o[%0d]", rp), rdAddrReady[rp], 1'b0);
        end else begin
            while (!rdAddrReady[rp]) begin
                @(negedge clk);
            end
            // Nothing returns before the address is taken
            checkHandshake($sformatf("rdDataValid_o[%0d]", rp), rdDataValid[rp], 1'b0);
            @(posedge clk);
            #2;
            // While stalled the same address is offered again and must wait
            rdAddrValid[rp] = (stallLeft > 0);
            rdDataReady[rp] = (stallLeft == 0);
            @(negedge clk);
            checkHandshake($sformatf("rdDataValid_o[%0d]", rp), rdDataValid[rp], 1'b1);
            checkData($sformatf("rdData_o[%0d]", rp), rdData[rp], expData);
            while (stallLeft > 0) begin
                checkHandshake($sformatf("rdAddrReady_o[%0d]", rp), rdAddrReady[rp], 1'b0);
                stallLeft--;
                @(posedge clk);
                #2;
                if (stallLeft == 0) begin
                    rdAddrValid[rp] = 1'b0;
                    rdDataReady[rp] = 1'b1;
                end
                @(negedge clk);
                checkHandshake($sformatf("rdDataValid_o[%0d]", rp), rdDataValid[rp], 1'b1);
                checkData($sformatf("rdData_o[%0d]", rp), rdData[rp], expData);
            end
            @(posedge clk);
            @(negedge clk);
            checkHandshake($sformatf("rdDataValid_o[%0d]", rp), rdDataValid[rp], 1'b0);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int lines;
        int fd;
        int code;
        logic [63:0] cmdWord;
        logic [31:0] argA;
        logic [31:0] argB;
        logic [31:0] argC;
        logic [31:0] argD;
        logic [8*128-1:0] restBuf;

        seed        = 32'hc5185cb4;
        cycleCount  = 0;
        cycleLimit  = 0;
        stallLeft   = 0;
        rst_n       = 1'b0;
        cfgBankMask = '0;
        cfgBypass   = '0;
        wrAddr      = '0;
        wrData      = '0;
        wrValid     = '0;
        rdAddr      = '0;
        rdAddrValid = '0;
        rdDataReady = '1;

        countFileLines(lines);
        cycleLimit = 40 * lines;

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        for (int p = 0; p < NUM_WRPORT; p++) begin
            checkHandshake($sformatf("wrReady_o[%0d]", p), wrReady[p], 1'b0);
        end
        for (int p = 0; p < NUM_RDPORT; p++) begin
            checkHandshake($sformatf("rdAddrReady_o[%0d]", p), rdAddrReady[p], 1'b0);
            checkHandshake($sformatf("rdDataValid_o[%0d]", p), rdDataValid[p], 1'b0);
        end

        // Offer traffic on every port while no bank is assigned
        @(posedge clk);
        #2;
        wrValid     = '1;
        rdAddrValid = '1;
        repeat (3) @(negedge clk);
        @(posedge clk);
        #2;
        wrValid     = '0;
        rdAddrValid = '0;

        fd = $fopen(TEST_FILE, "r");
        code = $fscanf(fd, "%s", cmdWord);
        while (code == 1) begin
            if (cmdWord == 64'("#")) begin
                code = $fgets(restBuf, fd);
            end else if (cmdWord == 64'("CFG")) begin
                code = $fscanf(fd, "%d %h %d", argA, argB, argC);
                verifyFieldCount(code, 3);
                applyConfig(argA[GP_W-1:0], argB[NUM_BANK-1:0], argC[0]);
                idleGap();
            end else if (cmdWord == 64'("WR")) begin
                code = $fscanf(fd, "%d %h %h %d", argA, argB, argC, argD);
                verifyFieldCount(code, 4);
                writeWord(argA[WP_W-1:0], argB[ADDR_WIDTH-1:0], argC, argD[0]);
                idleGap();
            end else if (cmdWord == 64'("RD")) begin
                code = $fscanf(fd, "%d %h %d %h", argA, argB, argC, argD);
                verifyFieldCount(code, 4);
                readWord(argA[RP_W-1:0], argB[ADDR_WIDTH-1:0], argC[0], argD);
                idleGap();
            end else if (cmdWord == 64'("STALL")) begin
                code = $fscanf(fd, "%d", argA);
                verifyFieldCount(code, 1);
                stallLeft = int'(argA);
            end else begin
                $display("Unknown command in test file");
                failRun();
            end
            code = $fscanf(fd, "%s", cmdWord);
        end
        $fclose(fd);

        $display("Test OK");
        $finish;
    end

endmodule

// ==== testbench/glbTests.txt ====
# CFG gport mask(hex) bypass | WR wport addr(hex) data(hex) expectFull
# RD rport addr(hex) expectEmpty expectData(hex) | STALL cycles for the next read
CFG 0 3 0
CFG 2 3 0
RD 0 00 1 00000000
WR 0 00 11110000 0
WR 0 05 22220005 0
WR 0 14 33330014 0
WR 0 1a 4444001a 0
WR 0 20 55550020 1
RD 0 00 0 11110000
RD 0 14 0 33330014
RD 0 1a 0 4444001a
RD 0 1b 1 00000000
WR 0 20 55550020 0
WR 0 3b 6666003b 1
STALL 3
RD 0 05 0 22220005
CFG 1 c 0
CFG 3 c 0
WR 1 03 77770003 0
WR 0 1c 8888001c 0
WR 1 13 99990013 0
RD 1 03 0 77770003
RD 0 1c 0 8888001c
RD 1 13 0 99990013
CFG 0 f 0
RD 1 03 1 00000000
CFG 3 c 1
RD 1 03 0 77770003
